// File: hdl/rvPkg.sv
`default_nettype none

package rvPkg;

    localparam int xlen = 32;

    // Base opcodes
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

    localparam logic [2:0] aluClassR      = 3'd0;
    localparam logic [2:0] aluClassI      = 3'd1;
    localparam logic [2:0] aluClassBranch = 3'd2;
    localparam logic [2:0] aluClassMem    = 3'd3;
    localparam logic [2:0] aluClassUpper  = 3'd4;
    localparam logic [2:0] aluClassJump   = 3'd5;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd
    } aluOp_t;

    // First ALU operand source
    localparam logic [1:0] upperPc   = 2'b00;
    localparam logic [1:0] upperZero = 2'b01;
    localparam logic [1:0] upperRs1  = 2'b10;

endpackage

`default_nettype wire

// File: hdl/singleControl.sv
`timescale 1ns/10ps
`default_nettype none

module singleControl (
    input  logic [6:0] instruction,
    output logic       branch,
    output logic       memRead,
    output logic       memToReg,
    output logic [2:0] aluClass,
    output logic       memWrite,
    output logic       aluSrc,
    output logic       regWrite,
    output logic [1:0] upperSrc,
    output logic       jump
);

    always_comb
    begin
        branch   = 1'b0;
        memRead  = 1'b0;
        memToReg = 1'b0;
        aluClass = rvPkg::aluClassR;
        memWrite = 1'b0;
        aluSrc   = 1'b0;
        regWrite = 1'b0;
        upperSrc = rvPkg::upperRs1;
        jump     = 1'b0;
        case (instruction)
            rvPkg::opR:
            begin
                regWrite = 1'b1;
            end
            rvPkg::opImm:
            begin
                aluClass = rvPkg::aluClassI;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            rvPkg::opBranch:
            begin
                branch   = 1'b1;
                aluClass = rvPkg::aluClassBranch;
            end
            rvPkg::opLoad:
            begin
                memRead  = 1'b1;
                memToReg = 1'b1;
                aluClass = rvPkg::aluClassMem;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            rvPkg::opStore:
            begin
                memWrite = 1'b1;
                aluClass = rvPkg::aluClassMem;
                aluSrc   = 1'b1;
            end
            rvPkg::opAuipc:
            begin
                aluClass = rvPkg::aluClassUpper;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                upperSrc = rvPkg::upperPc;
            end
            rvPkg::opLui:
            begin
                aluClass = rvPkg::aluClassUpper;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                upperSrc = rvPkg::upperZero;
            end
            rvPkg::opJal:
            begin
                aluClass = rvPkg::aluClassJump;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                upperSrc = rvPkg::upperPc; // Target is pc + imm
                jump     = 1'b1;
            end
            rvPkg::opJalr:
            begin
                aluClass = rvPkg::aluClassJump;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                jump     = 1'b1;
            end
            default:
            begin
                // Unknown opcode retires as a no-op
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile #(
    parameter int numRegs = 32
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       writeEn,
    input  logic [$clog2(numRegs)-1:0] readAddr1,
    input  logic [$clog2(numRegs)-1:0] readAddr2,
    input  logic [$clog2(numRegs)-1:0] writeAddr,
    input  logic [rvPkg::xlen-1:0]     writeData,
    output logic [rvPkg::xlen-1:0]     readData1,
    output logic [rvPkg::xlen-1:0]     readData2
);

    logic [rvPkg::xlen-1:0] regs [numRegs];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < numRegs; i++)
                regs[i] <= '0;
        end
        else if (writeEn && writeAddr != '0)
            regs[writeAddr] <= writeData; // x0 never written
    end

    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage #(
    parameter int numRegs = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            instr,
    input  logic [rvPkg::xlen-1:0] writeData,
    output logic [rvPkg::xlen-1:0] rs1Data,
    output logic [rvPkg::xlen-1:0] rs2Data,
    output logic [rvPkg::xlen-1:0] imm,
    output logic [2:0]             funct3,
    output logic                   funct7b5,
    output logic [2:0]             aluClass,
    output logic                   aluSrc,
    output logic [1:0]             upperSrc,
    output logic                   branch,
    output logic                   jump,
    output logic                   memRead,
    output logic                   memWrite,
    output logic                   memToReg,
    output logic                   regWriteEn,
    output logic [4:0]             regWriteAddr
);

    localparam int addrW = $clog2(numRegs);

    logic [6:0] opcode;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       regWrite;
    logic       storeStrobe;

    assign opcode       = instr[6:0];
    assign rs1          = instr[19:15];
    assign rs2          = instr[24:20];
    assign regWriteAddr = instr[11:7];
    assign funct3       = instr[14:12];
    assign funct7b5     = instr[30];

    always_comb
    begin
        case (opcode)
            rvPkg::opImm, rvPkg::opLoad, rvPkg::opJalr:
                imm = {{20{instr[31]}}, instr[31:20]};
            rvPkg::opStore:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rvPkg::opBranch:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            rvPkg::opAuipc, rvPkg::opLui:
                imm = {instr[31:12], 12'b0};
            rvPkg::opJal:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    // No architectural effects while in reset
    assign regWriteEn = regWrite & ~rst;
    assign memWrite   = storeStrobe & ~rst;

    singleControl singleControl_inst (
        .instruction (opcode),
        .branch      (branch),
        .memRead     (memRead),
        .memToReg    (memToReg),
        .aluClass    (aluClass),
        .memWrite    (storeStrobe),
        .aluSrc      (aluSrc),
        .regWrite    (regWrite),
        .upperSrc    (upperSrc),
        .jump        (jump)
    );

    regFile #(
        .numRegs (numRegs)
    ) regFile_inst (
        .clk       (clk),
        .rst       (rst),
        .writeEn   (regWriteEn),
        .readAddr1 (rs1[addrW-1:0]),
        .readAddr2 (rs2[addrW-1:0]),
        .writeAddr (regWriteAddr[addrW-1:0]),
        .writeData (writeData),
        .readData1 (rs1Data),
        .readData2 (rs2Data)
    );

endmodule

`default_nettype wire

// File: hdl/executeStage.sv
`timescale 1ns/10ps
`default_nettype none

module executeStage (
    input  logic [rvPkg::xlen-1:0] pc,
    input  logic [rvPkg::xlen-1:0] rs1Data,
    input  logic [rvPkg::xlen-1:0] rs2Data,
    input  logic [rvPkg::xlen-1:0] imm,
    input  logic [2:0]             funct3,
    input  logic                   funct7b5,
    input  logic [2:0]             aluClass,
    input  logic                   aluSrc,
    input  logic [1:0]             upperSrc,
    input  logic                   branch,
    input  logic                   jump,
    output logic [rvPkg::xlen-1:0] aluResult,
    output logic [rvPkg::xlen-1:0] nextPc,
    output logic [rvPkg::xlen-1:0] pcPlus4
);

    localparam int shW = $clog2(rvPkg::xlen);

    rvPkg::aluOp_t          aluOp;
    logic [rvPkg::xlen-1:0] opA;
    logic [rvPkg::xlen-1:0] opB;
    logic [shW-1:0]         shamt;
    logic                   cond;
    logic                   taken;

    always_comb
    begin
        case (aluClass)
            rvPkg::aluClassR, rvPkg::aluClassI:
                case (funct3)
                    3'b000: aluOp = (funct7b5 && aluClass == rvPkg::aluClassR) ?
                                    rvPkg::aluSub : rvPkg::aluAdd; // addi has no subi
                    3'b001: aluOp = rvPkg::aluSll;
                    3'b010: aluOp = rvPkg::aluSlt;
                    3'b011: aluOp = rvPkg::aluSltu;
                    3'b100: aluOp = rvPkg::aluXor;
                    3'b101: aluOp = funct7b5 ? rvPkg::aluSra : rvPkg::aluSrl;
                    3'b110: aluOp = rvPkg::aluOr;
                    default: aluOp = rvPkg::aluAnd;
                endcase
            rvPkg::aluClassBranch:
                aluOp = rvPkg::aluSub;
            default:
                aluOp = rvPkg::aluAdd; // Address and target sums
        endcase
    end

    always_comb
    begin
        case (upperSrc)
            rvPkg::upperPc:   opA = pc;
            rvPkg::upperZero: opA = '0;
            default:          opA = rs1Data;
        endcase
    end

    assign opB   = aluSrc ? imm : rs2Data;
    assign shamt = opB[shW-1:0];

    always_comb
    begin
        case (aluOp)
            rvPkg::aluAdd:  aluResult = opA + opB;
            rvPkg::aluSub:  aluResult = opA - opB;
            rvPkg::aluSll:  aluResult = opA << shamt;
            rvPkg::aluSlt:  aluResult = {{(rvPkg::xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
            rvPkg::aluSltu: aluResult = {{(rvPkg::xlen-1){1'b0}}, opA < opB};
            rvPkg::aluXor:  aluResult = opA ^ opB;
            rvPkg::aluSrl:  aluResult = opA >> shamt;
            rvPkg::aluSra:  aluResult = $signed(opA) >>> shamt;
            rvPkg::aluOr:   aluResult = opA | opB;
            default:        aluResult = opA & opB;
        endcase
    end

    always_comb
    begin
        case (funct3)
            3'b000:  cond = rs1Data == rs2Data;
            3'b001:  cond = rs1Data != rs2Data;
            3'b100:  cond = $signed(rs1Data) < $signed(rs2Data);
            3'b101:  cond = $signed(rs1Data) >= $signed(rs2Data);
            3'b110:  cond = rs1Data < rs2Data;
            3'b111:  cond = rs1Data >= rs2Data;
            default: cond = 1'b0;
        endcase
    end

    assign taken   = branch & cond;
    assign pcPlus4 = pc + 'd4;

    // JAL and JALR targets both come out of the ALU
    assign nextPc = jump  ? {aluResult[rvPkg::xlen-1:1], 1'b0} :
                    taken ? pc + imm :
                            pcPlus4;

endmodule

`default_nettype wire

// File: hdl/resultStage.sv
`timescale 1ns/10ps
`default_nettype none

module resultStage (
    input  logic [rvPkg::xlen-1:0]   aluResult,
    input  logic [rvPkg::xlen-1:0]   pcPlus4,
    input  logic [rvPkg::xlen-1:0]   rs2Data,
    input  logic [2:0]               funct3,
    input  logic                     memToReg,
    input  logic                     jump,
    input  logic [rvPkg::xlen-1:0]   memReadData,
    output logic [rvPkg::xlen/8-1:0] memByteEn,
    output logic [rvPkg::xlen-1:0]   memWriteData,
    output logic [rvPkg::xlen-1:0]   writeData
);

    logic [1:0]             byteOff;
    logic [rvPkg::xlen-1:0] loadShifted;
    logic [rvPkg::xlen-1:0] loadData;

    assign byteOff = aluResult[1:0];

    always_comb
    begin
        case (funct3[1:0])
            2'b00:
            begin
                memByteEn    = 4'b0001 << byteOff;
                memWriteData = {4{rs2Data[7:0]}};
            end
            2'b01:
            begin
                memByteEn    = 4'b0011 << {byteOff[1], 1'b0};
                memWriteData = {2{rs2Data[15:0]}};
            end
            default:
            begin
                memByteEn    = 4'b1111;
                memWriteData = rs2Data;
            end
        endcase
    end

    assign loadShifted = memReadData >> {byteOff, 3'b000}; // Addressed lane to bit 0

    always_comb
    begin
        case (funct3)
            3'b000:  loadData = {{24{loadShifted[7]}}, loadShifted[7:0]};
            3'b001:  loadData = {{16{loadShifted[15]}}, loadShifted[15:0]};
            3'b100:  loadData = {24'b0, loadShifted[7:0]};
            3'b101:  loadData = {16'b0, loadShifted[15:0]};
            default: loadData = memReadData;
        endcase
    end

    assign writeData = jump     ? pcPlus4 :
                       memToReg ? loadData :
                                  aluResult;

endmodule

`default_nettype wire

// File: hdl/singleCycleCore.sv
`timescale 1ns/10ps
`default_nettype none

module singleCycleCore #(
    parameter int                     numRegs   = 32,
    parameter logic [rvPkg::xlen-1:0] resetAddr = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [31:0]              instr,
    input  logic [rvPkg::xlen-1:0]   memReadData,
    output logic [rvPkg::xlen-1:0]   instrAddr,
    output logic [rvPkg::xlen-1:0]   memAddr,
    output logic [rvPkg::xlen-1:0]   memWriteData,
    output logic [rvPkg::xlen/8-1:0] memByteEn,
    output logic                     memWrite,
    output logic                     memRead,
    output logic                     regWriteEn,
    output logic [4:0]               regWriteAddr,
    output logic [rvPkg::xlen-1:0]   regWriteData
);

    logic [rvPkg::xlen-1:0] pc;
    logic [rvPkg::xlen-1:0] rs1Data;
    logic [rvPkg::xlen-1:0] rs2Data;
    logic [rvPkg::xlen-1:0] imm;
    logic [2:0]             funct3;
    logic                   funct7b5;
    logic [2:0]             aluClass;
    logic                   aluSrc;
    logic [1:0]             upperSrc;
    logic                   branch;
    logic                   jump;
    logic                   memToReg;
    logic [rvPkg::xlen-1:0] aluResult;
    logic [rvPkg::xlen-1:0] nextPc;
    logic [rvPkg::xlen-1:0] pcPlus4;

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= resetAddr;
        else
            pc <= nextPc; // One instruction retires per edge
    end

    assign instrAddr = pc;
    assign memAddr   = {aluResult[rvPkg::xlen-1:2], 2'b00};

    decodeStage #(
        .numRegs (numRegs)
    ) decodeStage_inst (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .writeData    (regWriteData),
        .rs1Data      (rs1Data),
        .rs2Data      (rs2Data),
        .imm          (imm),
        .funct3       (funct3),
        .funct7b5     (funct7b5),
        .aluClass     (aluClass),
        .aluSrc       (aluSrc),
        .upperSrc     (upperSrc),
        .branch       (branch),
        .jump         (jump),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memToReg     (memToReg),
        .regWriteEn   (regWriteEn),
        .regWriteAddr (regWriteAddr)
    );

    executeStage executeStage_inst (
        .pc        (pc),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .imm       (imm),
        .funct3    (funct3),
        .funct7b5  (funct7b5),
        .aluClass  (aluClass),
        .aluSrc    (aluSrc),
        .upperSrc  (upperSrc),
        .branch    (branch),
        .jump      (jump),
        .aluResult (aluResult),
        .nextPc    (nextPc),
        .pcPlus4   (pcPlus4)
    );

    resultStage resultStage_inst (
        .aluResult    (aluResult),
        .pcPlus4      (pcPlus4),
        .rs2Data      (rs2Data),
        .funct3       (funct3),
        .memToReg     (memToReg),
        .jump         (jump),
        .memReadData  (memReadData),
        .memByteEn    (memByteEn),
        .memWriteData (memWriteData),
        .writeData    (regWriteData)
    );

endmodule

`default_nettype wire

// File: bench/coreChecker.sv
`timescale 1ns/10ps
`default_nettype none

module coreChecker (
    input  logic        clk,
    input  logic        rst,
    input  logic        regWriteEn,
    input  logic [4:0]  regWriteAddr,
    input  logic [31:0] regWriteData,
    input  logic        memWrite,
    input  logic        memRead,
    input  logic [31:0] memAddr,
    input  logic [31:0] memWriteData,
    input  logic [3:0]  memByteEn,
    input  logic [31:0] expKind,
    input  logic [31:0] expWhere,
    input  logic [31:0] expValue,
    output int          eventIdx,
    output logic        traceDone,
    output int          valueErrors,
    output int          extraEvents,
    output int          strobeErrors
);

    localparam logic [31:0] kindReg   = 32'd1;
    localparam logic [31:0] kindStore = 32'd2;
    localparam logic [31:0] traceEnd  = 32'hffffffff;

    logic        seen;
    logic [31:0] kind;
    logic [31:0] where;
    logic [31:0] value;

    // Lowest enabled lane is the byte address offset
    function automatic logic [1:0] laneOffset(input logic [3:0] byteEn);
        if (byteEn[0])
            return 2'd0;
        else if (byteEn[1])
            return 2'd1;
        else if (byteEn[2])
            return 2'd2;
        else
            return 2'd3;
    endfunction

    function automatic logic [31:0] laneValue(input logic [31:0] data, input logic [3:0] byteEn);
        case (byteEn)
            4'b0001: return {24'b0, data[7:0]};
            4'b0010: return {24'b0, data[15:8]};
            4'b0100: return {24'b0, data[23:16]};
            4'b1000: return {24'b0, data[31:24]};
            4'b0011: return {16'b0, data[15:0]};
            4'b1100: return {16'b0, data[31:16]};
            default: return data;
        endcase
    endfunction

    assign traceDone = expKind == traceEnd;

    always_comb
    begin
        seen  = 1'b0;
        kind  = '0;
        where = '0;
        value = '0;
        if (regWriteEn && regWriteAddr != '0)
        begin
            seen  = 1'b1;
            kind  = kindReg;
            where = {27'b0, regWriteAddr};
            value = regWriteData;
        end
        else if (memWrite)
        begin
            seen  = 1'b1;
            kind  = kindStore;
            where = {memAddr[31:2], laneOffset(memByteEn)};
            value = laneValue(memWriteData, memByteEn);
        end
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            eventIdx     <= 0;
            valueErrors  <= 0;
            extraEvents  <= 0;
            strobeErrors <= 0;
        end
        else
        begin
            if (memRead && memWrite)
            begin
                $display("Read strobe high during a store at %0t", $time);
                strobeErrors <= strobeErrors + 1;
            end
            if (seen && traceDone)
            begin
                $display("Unexpected event after the end of the trace at %0t: kind %0d at %h value %h",
                         $time, kind, where, value);
                extraEvents <= extraEvents + 1;
            end
            else if (seen)
            begin
                if (kind != expKind || where != expWhere || value != expValue)
                begin
                    $display("FAILED %0t: event %0d expected %0d %h %h, got %0d %h %h",
                             $time, eventIdx, expKind, expWhere, expValue, kind, where, value);
                    valueErrors <= valueErrors + 1;
                end
                eventIdx <= eventIdx + 1; // Next triple
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tbCore.sv
`timescale 1ns/10ps
`default_nettype none

module tbCore;

    localparam int progWords = 64;
    localparam int traceBase = 64;
    localparam int maxCycles = 2 * progWords + 20;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] memReadData;
    logic [31:0] instrAddr;
    logic [31:0] memAddr;
    logic [31:0] memWriteData;
    logic [3:0]  memByteEn;
    logic        memWrite;
    logic        memRead;
    logic        regWriteEn;
    logic [4:0]  regWriteAddr;
    logic [31:0] regWriteData;
    logic [31:0] golden [256];
    logic [7:0]  dataMem [256];
    logic [7:0]  traceIdx;
    logic [5:0]  wordSel;
    logic        traceDone;
    logic        progEnd;
    int          eventIdx;
    int          valueErrors;
    int          extraEvents;
    int          strobeErrors;
    int          timeouts;
    int          cycleCount = 0;
    integer      seed;

    singleCycleCore #(
        .numRegs   (32),
        .resetAddr (32'h0)
    ) singleCycleCore_inst (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .memReadData  (memReadData),
        .instrAddr    (instrAddr),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memByteEn    (memByteEn),
        .memWrite     (memWrite),
        .memRead      (memRead),
        .regWriteEn   (regWriteEn),
        .regWriteAddr (regWriteAddr),
        .regWriteData (regWriteData)
    );

    assign traceIdx = 8'(traceBase + 3 * eventIdx);

    coreChecker coreChecker_inst (
        .clk          (clk),
        .rst          (rst),
        .regWriteEn   (regWriteEn),
        .regWriteAddr (regWriteAddr),
        .regWriteData (regWriteData),
        .memWrite     (memWrite),
        .memRead      (memRead),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memByteEn    (memByteEn),
        .expKind      (golden[traceIdx]),
        .expWhere     (golden[traceIdx + 8'd1]),
        .expValue     (golden[traceIdx + 8'd2]),
        .eventIdx     (eventIdx),
        .traceDone    (traceDone),
        .valueErrors  (valueErrors),
        .extraEvents  (extraEvents),
        .strobeErrors (strobeErrors)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
        cycleCount <= cycleCount + 1;

    // Zero words past the image retire as no-ops
    always_comb
    begin
        if (instrAddr < 32'(4 * progWords))
            instr = golden[{2'b00, instrAddr[7:2]}];
        else
            instr = '0;
    end

    assign wordSel = memAddr[7:2];
    assign progEnd = instrAddr >= 32'(4 * progWords);

    always_comb
    begin
        if (!memRead || $isunknown(memAddr))
            memReadData = '0; // Data only while a load reads
        else
            memReadData = {dataMem[{wordSel, 2'b11}], dataMem[{wordSel, 2'b10}],
                           dataMem[{wordSel, 2'b01}], dataMem[{wordSel, 2'b00}]};
    end

    always @(posedge clk)
    begin
        if (memWrite)
        begin
            for (int b = 0; b < 4; b++)
                if (memByteEn[b])
                    dataMem[{wordSel, 2'(b)}] <= memWriteData[8*b +: 8];
        end
    end

    initial
    begin
        rst      = 1'b1;
        timeouts = 0;
        seed     = 32'hb838;
        for (int i = 0; i < 256; i++)
            golden[i] = '0;
        $readmemh("bench/coreGolden.mem", golden);
        for (int i = 0; i < 256; i++)
            dataMem[i] <= 8'($random(seed)); // Program reads only what it stored
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        while (!(traceDone && progEnd) && cycleCount < maxCycles)
            @(negedge clk);
        if (!(traceDone && progEnd))
        begin
            $display("Timeout after %0d cycles with the trace unfinished at event %0d",
                     cycleCount, eventIdx);
            timeouts = 1;
        end
        $display("Summary: %0d mismatches, %0d unexpected events, %0d strobe errors, %0d timeouts",
                 valueErrors, extraEvents, strobeErrors, timeouts);
        if (valueErrors + extraEvents + strobeErrors + timeouts == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/coreGolden.mem
// Words 0-63: program image, one instruction word per entry
// From @40: kind (1 reg write, 2 store), register or byte address, value; ffffffff ends
00500093 ffd00113 002081b3 40208233 001092b3 00112333 001133b3 0020c433
001154b3 40115533 0020e5b3 0020f633 ffe12693 fff0b713 7ff0c793 1000e813
0f017893 01c09913 01c15993 40115a13 00708013 00100ab3 12345b37 00001b97
08000c13 016c2023 011c00a3 014c1123 001c0d03 001c4d83 002c1e03 002c5e83
000c2f03 00208463 00c08463 00100f93 00c09463 00209463 00100f93 0020c463
00114463 00100f93 00115463 0020d463 00100f93 00116463 0020e463 00100f93
0020f463 00117463 00100f93 00c000ef 00100f93 00100f93 0e900293 00428367
00100f93 00100f93 00100f93 00000397 00100f8b 07b00f93 01fc2223 00000000
@40
1 01 00000005
1 02 fffffffd
1 03 00000002
1 04 00000008
1 05 000000a0
1 06 00000001
1 07 00000000
1 08 fffffff8
1 09 07ffffff
1 0a ffffffff
1 0b fffffffd
1 0c 00000005
1 0d 00000001
1 0e 00000001
1 0f 000007fa
1 10 00000105
1 11 000000f0
1 12 50000000
1 13 0000000f
1 14 fffffffe
// x0 write leaves no event, x0 reads back as zero
1 15 00000005
1 16 12345000
1 17 0000105c
1 18 00000080
2 80 12345000
2 81 000000f0
2 82 0000fffe
1 1a fffffff0
1 1b 000000f0
1 1c fffffffe
1 1d 0000fffe
1 1e fffef000
// Branch block gives no events
1 01 000000d0
1 05 000000e9
1 06 000000e0
1 07 000000ec
1 1f 0000007b
2 84 0000007b
ffffffff

// File: sources.f
hdl/rvPkg.sv
hdl/singleControl.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/resultStage.sv
hdl/singleCycleCore.sv
bench/coreChecker.sv
bench/tbCore.sv

// File: Makefile
SIM := obj_dir/VtbCore

.PHONY: all run clean

all: run

$(SIM): sources.f $(wildcard hdl/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing -Wno-fatal --top-module tbCore -f sources.f -o VtbCore

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
